// ==== hdl/video_pkg.sv ====
package video_pkg;

    // Raster geometry, fixed at build time
    localparam int PIXEL_DIV      = 2;   // Bus clocks per pixel
    localparam int CHAR_PIXELS    = 16;  // Pixels per character clock (two characters)
    localparam int H_TOTAL        = 12;  // Character clocks per line
    localparam int H_DISPLAY      = 8;   // Visible character clocks per line
    localparam int H_SYNC_START   = 9;   // First character clock of hsync
    localparam int H_SYNC_WIDTH   = 2;   // Hsync length in character clocks
    localparam int RA_TOTAL       = 10;  // Scanlines per text row
    localparam int GLYPH_LINES    = 8;   // Glyph height, lines below are blank
    localparam int V_ROWS_TOTAL   = 4;   // Text rows per frame
    localparam int V_ROWS_DISPLAY = 3;   // Visible text rows
    localparam int V_SYNC_ROW     = 3;   // Row where vsync begins
    localparam int V_SYNC_LINES   = 2;   // Vsync length in scanlines

    // Bus and address widths
    localparam int WB_ADDR_WIDTH   = 16;
    localparam int DATA_WIDTH      = 8;
    localparam int MA_WIDTH        = 10;  // Character-pair address
    localparam int RA_WIDTH        = 4;   // Scanline within a row
    localparam int ROM_INDEX_WIDTH = 11;  // graphic + code[6:0] + ra[2:0]

    // Counter widths derived from the geometry
    localparam int PRESC_WIDTH = $clog2(PIXEL_DIV);
    localparam int PIX_WIDTH   = $clog2(CHAR_PIXELS);
    localparam int H_WIDTH     = $clog2(H_TOTAL);
    localparam int ROW_WIDTH   = $clog2(V_ROWS_TOTAL);

    typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;  // Bus address
    typedef logic [DATA_WIDTH-1:0]    byte_t;     // Bus data, screen code or glyph byte
    typedef logic [MA_WIDTH-1:0]      ma_t;
    typedef logic [RA_WIDTH-1:0]      ra_t;

    localparam wb_addr_t VRAM_BASE = 16'h8000;  // Screen RAM window
    localparam wb_addr_t VROM_BASE = 16'hC000;  // Character ROM window

    // Order of the four reads per character clock
    typedef enum logic [1:0] {
        EVEN_RAM,
        EVEN_ROM,
        ODD_RAM,
        ODD_ROM
    } fetch_stage_e;

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        AWAIT_ACK
    } fetch_state_e;

    // Raster position and strobes, all active high
    typedef struct packed {
        ma_t  ma;
        ra_t  ra;
        logic de;
        logic h_sync;
        logic v_sync;
    } raster_t;

endpackage

// ==== hdl/video_timing.sv ====
`timescale 1ns/100ps

module video_timing (
    input  logic               wb_clock_i,  // Bus clock
    input  logic               rst_n_i,     // Sync reset, active low
    output logic               pixel_en_o,  // One clock in PIXEL_DIV
    output logic               cclk_en_o,   // One clock per character pair
    output video_pkg::raster_t raster_o     // Position of the pair to fetch next
);
    import video_pkg::*;

    logic [PRESC_WIDTH-1:0] presc_q;  // Bus clocks within a pixel
    logic [PIX_WIDTH-1:0]   pix_q;    // Pixel within the character pair
    logic [H_WIDTH-1:0]     h_q;      // Character clock within the line
    ra_t                    ra_q;     // Scanline within the text row
    logic [ROW_WIDTH-1:0]   row_q;    // Text row within the frame
    logic                   line_end;
    logic                   row_end;
    logic                   frame_end;

    assign pixel_en_o = (presc_q == PRESC_WIDTH'(PIXEL_DIV - 1));
    assign cclk_en_o  = pixel_en_o && (pix_q == PIX_WIDTH'(CHAR_PIXELS - 1));
    assign line_end   = (h_q == H_WIDTH'(H_TOTAL - 1));
    assign row_end    = (ra_q == RA_WIDTH'(RA_TOTAL - 1));
    assign frame_end  = (row_q == ROW_WIDTH'(V_ROWS_TOTAL - 1));

    // Pixel prescaler and pixel counter
    always_ff @(posedge wb_clock_i) begin
        if (!rst_n_i) begin
            presc_q <= '0;
            pix_q   <= '0;
        end else begin
            if (pixel_en_o) begin
                presc_q <= '0;
            end else begin
                presc_q <= presc_q + 1'b1;
            end
            if (cclk_en_o) begin
                pix_q <= '0;                  // Wrap at the pair boundary
            end else if (pixel_en_o) begin
                pix_q <= pix_q + 1'b1;
            end
        end
    end

    // Horizontal, scanline and row counters step on the character clock
    always_ff @(posedge wb_clock_i) begin
        if (!rst_n_i) begin
            h_q   <= '0;
            ra_q  <= '0;
            row_q <= '0;
        end else if (cclk_en_o) begin
            if (!line_end) begin
                h_q <= h_q + 1'b1;
            end else begin
                h_q <= '0;
                if (!row_end) begin
                    ra_q <= ra_q + 1'b1;
                end else begin
                    ra_q  <= '0;
                    row_q <= frame_end ? '0 : row_q + 1'b1;
                end
            end
        end
    end

    // Decode of the counters, moves only in the clock after cclk_en
    always_comb begin
        raster_o.ma     = ma_t'(row_q) * ma_t'(H_DISPLAY) + ma_t'(h_q);
        raster_o.ra     = ra_q;
        raster_o.de     = (h_q < H_WIDTH'(H_DISPLAY)) &&
                          (row_q < ROW_WIDTH'(V_ROWS_DISPLAY));
        raster_o.h_sync = (h_q >= H_WIDTH'(H_SYNC_START)) &&
                          (h_q < H_WIDTH'(H_SYNC_START + H_SYNC_WIDTH));
        raster_o.v_sync = (row_q == ROW_WIDTH'(V_SYNC_ROW)) &&
                          (ra_q < RA_WIDTH'(V_SYNC_LINES));  // First lines of the sync row
    end

    ra_range_a: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        ra_q < RA_WIDTH'(RA_TOTAL));

    // Visible window must map inside the screen RAM in use
    ma_visible_a: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        raster_o.de |-> raster_o.ma < ma_t'(V_ROWS_DISPLAY * H_DISPLAY));

endmodule

// ==== hdl/video_fetch_ctrl.sv ====
`timescale 1ns/100ps

module video_fetch_ctrl (
    input  logic                    wb_clock_i,   // Bus clock
    input  logic                    rst_n_i,      // Sync reset, active low
    input  logic                    cclk_en_i,    // Starts the fetch of one pair
    input  video_pkg::raster_t      raster_i,     // Position of the pair to fetch
    input  logic                    graphic_i,    // Character set select
    input  video_pkg::byte_t        even_code_i,  // Captured even screen code
    input  video_pkg::byte_t        odd_code_i,   // Captured odd screen code
    input  logic                    wb_stall_i,   // Slave not ready for a request
    input  logic                    wb_ack_i,     // Read data valid
    output video_pkg::wb_addr_t     wb_addr_o,    // Read address
    output logic                    wb_cyc_o,     // Bus cycle held from the first request
    output logic                    wb_stb_o,     // Request valid
    output logic                    wb_we_o,      // Always read
    output logic                    cap_en_o,     // Capture strobe for the buffer
    output video_pkg::fetch_stage_e stage_o       // Which byte is being read
);
    import video_pkg::*;

    fetch_state_e                state_q;
    fetch_stage_e                stage_q;
    raster_t                     raster_q;   // Pair position held for the four reads
    logic                        graphic_q;  // Charset held for the four reads
    logic                        cyc_q;
    logic [MA_WIDTH:0]           ram_offset;
    byte_t                       rom_code;
    logic [ROM_INDEX_WIDTH-1:0]  rom_index;

    assign wb_cyc_o = cyc_q;
    assign wb_stb_o = (state_q == REQUEST);
    assign wb_we_o  = 1'b0;
    assign cap_en_o = (state_q == AWAIT_ACK) && wb_ack_i;
    assign stage_o  = stage_q;

    // Two bytes per pair in VRAM, even first
    assign ram_offset = {raster_q.ma, stage_q == ODD_RAM};
    assign rom_code   = (stage_q == EVEN_ROM) ? even_code_i : odd_code_i;
    // Bit 7 of the code is reverse video, not part of the glyph index
    assign rom_index  = {graphic_q, rom_code[6:0], raster_q.ra[2:0]};

    // Address depends on registered values only, so it holds under stall
    always_comb begin
        case (stage_q)
            EVEN_RAM, ODD_RAM: wb_addr_o = VRAM_BASE + wb_addr_t'(ram_offset);
            default:           wb_addr_o = VROM_BASE + wb_addr_t'(rom_index);
        endcase
    end

    always_ff @(posedge wb_clock_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            stage_q <= EVEN_RAM;
            cyc_q   <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (cclk_en_i) begin
                        state_q <= REQUEST;
                        stage_q <= EVEN_RAM;
                        cyc_q   <= 1'b1;     // Never dropped again
                    end
                end

                REQUEST: begin
                    if (!wb_stall_i) begin
                        state_q <= AWAIT_ACK;  // Request taken
                    end
                end

                AWAIT_ACK: begin
                    if (wb_ack_i) begin
                        if (stage_q == ODD_ROM) begin
                            state_q <= IDLE;   // Pair complete
                        end else begin
                            state_q <= REQUEST;
                            stage_q <= fetch_stage_e'(stage_q + 2'd1);
                        end
                    end
                end

                default: state_q <= IDLE;
            endcase
        end
    end

    // Timing moves on at cclk_en, keep a private copy
    always_ff @(posedge wb_clock_i) begin
        if (state_q == IDLE && cclk_en_i) begin
            raster_q  <= raster_i;
            graphic_q <= graphic_i;
        end
    end

    // All four reads must finish within one character clock
    idle_at_cclk_a: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        cclk_en_i |-> state_q == IDLE);

    // Back-pressure keeps the request on the bus unchanged
    stall_hold_a: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        (wb_stb_o && wb_stall_i) |=> (wb_stb_o && $stable(wb_addr_o)));

endmodule

// ==== hdl/video_fetch_buf.sv ====
`timescale 1ns/100ps

module video_fetch_buf (
    input  logic                               wb_clock_i,   // Bus clock
    input  logic                               rst_n_i,      // Sync reset, active low
    input  logic                               cap_en_i,     // Ack of the current read
    input  video_pkg::fetch_stage_e            stage_i,      // Slot for the read data
    input  video_pkg::byte_t                   wb_data_i,    // Read data
    input  logic                               cclk_en_i,    // Pair boundary
    output video_pkg::byte_t                   even_code_o,  // For the even ROM address
    output video_pkg::byte_t                   odd_code_o,   // For the odd ROM address
    output logic [video_pkg::CHAR_PIXELS-1:0]  glyph_o,      // Even byte high, odd byte low
    output logic [1:0]                         reverse_o     // [1] even, [0] odd
);
    import video_pkg::*;

    byte_t cap_q [4];  // One slot per fetch stage
    logic  full_q;     // All four bytes of the pair are in

    assign even_code_o = cap_q[EVEN_RAM];
    assign odd_code_o  = cap_q[ODD_RAM];

    // Capture slots, overwritten by the next pair after the dot generator loads
    always_ff @(posedge wb_clock_i) begin
        if (cap_en_i) begin
            cap_q[stage_i] <= wb_data_i;
        end
    end

    // Set by the last read of a pair, consumed at the next character clock
    always_ff @(posedge wb_clock_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
        end else if (cclk_en_i) begin
            full_q <= 1'b0;
        end else if (cap_en_i && stage_i == ODD_ROM) begin
            full_q <= 1'b1;
        end
    end

    // Incomplete pair is handed over as blank
    always_comb begin
        if (full_q) begin
            glyph_o   = {cap_q[EVEN_ROM], cap_q[ODD_ROM]};
            reverse_o = {cap_q[EVEN_RAM][7], cap_q[ODD_RAM][7]};  // Bit 7 selects reverse
        end else begin
            glyph_o   = '0;
            reverse_o = '0;
        end
    end

endmodule

// ==== hdl/video_dotgen.sv ====
`timescale 1ns/100ps

module video_dotgen (
    input  logic                              wb_clock_i,    // Bus clock
    input  logic                              rst_n_i,       // Sync reset, active low
    input  logic                              pixel_en_i,    // Advance one pixel
    input  logic                              cclk_en_i,     // Load the next pair
    input  logic [video_pkg::CHAR_PIXELS-1:0] glyph_i,       // Even byte high, odd byte low
    input  logic [1:0]                        reverse_i,     // [1] even, [0] odd
    input  video_pkg::raster_t                raster_i,      // Position of the pair in fetch
    input  logic                              config_crt_i,  // 0 = 12" CRT, 1 = 9" CRT
    output logic                              h_sync_o,      // Horizontal sync
    output logic                              v_sync_o,      // Vertical sync
    output logic                              video_o        // Pixel out
);
    import video_pkg::*;

    localparam int HALF = CHAR_PIXELS / 2;

    logic [CHAR_PIXELS-1:0] shift_q;   // MSB is the pixel on screen
    raster_t                raster_q;  // Raster of the pair being fetched
    logic                   gate_q;    // Display enable minus blank scanlines
    logic                   h_sync_q;
    logic                   v_sync_q;

    // Reverse is folded in at load, one bit per character half
    always_ff @(posedge wb_clock_i) begin
        if (cclk_en_i) begin
            shift_q <= glyph_i ^ {{HALF{reverse_i[1]}}, {HALF{reverse_i[0]}}};
        end else if (pixel_en_i) begin
            shift_q <= {shift_q[CHAR_PIXELS-2:0], 1'b0};  // MSB first
        end
    end

    // Syncs and gate lag the fetch by one character clock
    always_ff @(posedge wb_clock_i) begin
        if (!rst_n_i) begin
            raster_q <= '0;
            gate_q   <= 1'b0;
            h_sync_q <= 1'b0;
            v_sync_q <= 1'b0;
        end else if (cclk_en_i) begin
            gate_q   <= raster_q.de && (raster_q.ra < RA_WIDTH'(GLYPH_LINES));
            h_sync_q <= raster_q.h_sync;
            v_sync_q <= raster_q.v_sync;
            raster_q <= raster_i;        // Pair whose bytes are now being read
        end
    end

    // 12" CRT wants low syncs and high video, the 9" the opposite
    assign h_sync_o = h_sync_q ^ ~config_crt_i;
    assign v_sync_o = v_sync_q ^ ~config_crt_i;
    assign video_o  = (shift_q[CHAR_PIXELS-1] & gate_q) ^ config_crt_i;

endmodule

// ==== hdl/video_top.sv ====
`timescale 1ns/100ps

module video_top (
    input  logic                wb_clock_i,    // Bus clock
    input  logic                rst_n_i,       // Sync reset, active low
    input  logic                graphic_i,     // Character set select
    input  logic                config_crt_i,  // 0 = 12" CRT, 1 = 9" CRT
    output video_pkg::wb_addr_t wb_addr_o,     // Wishbone master, pipelined B4
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    output logic                wb_we_o,
    input  video_pkg::byte_t    wb_data_i,
    input  logic                wb_stall_i,
    input  logic                wb_ack_i,
    output logic                h_sync_o,      // Horizontal sync
    output logic                v_sync_o,      // Vertical sync
    output logic                video_o        // Pixel out
);
    import video_pkg::*;

    logic                   pixel_en;
    logic                   cclk_en;
    raster_t                raster;
    logic                   cap_en;
    fetch_stage_e           stage;
    byte_t                  even_code;
    byte_t                  odd_code;
    logic [CHAR_PIXELS-1:0] glyph;
    logic [1:0]             reverse;

    video_timing u_timing (
        .wb_clock_i (wb_clock_i),
        .rst_n_i    (rst_n_i),
        .pixel_en_o (pixel_en),
        .cclk_en_o  (cclk_en),
        .raster_o   (raster)
    );

    video_fetch_ctrl u_fetch_ctrl (
        .wb_clock_i  (wb_clock_i),
        .rst_n_i     (rst_n_i),
        .cclk_en_i   (cclk_en),
        .raster_i    (raster),
        .graphic_i   (graphic_i),
        .even_code_i (even_code),
        .odd_code_i  (odd_code),
        .wb_stall_i  (wb_stall_i),
        .wb_ack_i    (wb_ack_i),
        .wb_addr_o   (wb_addr_o),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_we_o     (wb_we_o),
        .cap_en_o    (cap_en),
        .stage_o     (stage)
    );

    video_fetch_buf u_fetch_buf (
        .wb_clock_i  (wb_clock_i),
        .rst_n_i     (rst_n_i),
        .cap_en_i    (cap_en),
        .stage_i     (stage),
        .wb_data_i   (wb_data_i),
        .cclk_en_i   (cclk_en),
        .even_code_o (even_code),
        .odd_code_o  (odd_code),
        .glyph_o     (glyph),
        .reverse_o   (reverse)
    );

    video_dotgen u_dotgen (
        .wb_clock_i   (wb_clock_i),
        .rst_n_i      (rst_n_i),
        .pixel_en_i   (pixel_en),
        .cclk_en_i    (cclk_en),
        .glyph_i      (glyph),
        .reverse_i    (reverse),
        .raster_i     (raster),
        .config_crt_i (config_crt_i),
        .h_sync_o     (h_sync_o),
        .v_sync_o     (v_sync_o),
        .video_o      (video_o)
    );

endmodule

// ==== testbench/tb_wb_memory.sv ====
`timescale 1ns/100ps

module tb_wb_memory (
    input  logic                wb_clock_i,   // Bus clock
    input  logic                rst_n_i,      // Sync reset, active low
    input  video_pkg::wb_addr_t wb_addr_i,    // Read address from the master
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  int                  stall_max_i,  // Longest stall drawn per request
    input  video_pkg::byte_t    code_key_i,   // XOR pattern of the screen codes
    output video_pkg::byte_t    wb_data_o,    // Read data, valid with ack
    output logic                wb_stall_o,
    output logic                wb_ack_o
);
    import video_pkg::*;

    wb_addr_t   addr_q;   // Address of the accepted request
    logic       busy_q;   // One request outstanding
    logic [1:0] stall_q;  // Stall cycles left for the next request
    logic [1:0] ack_q;    // Cycles left until ack

    // VRAM holds offset XOR key, VROM holds offset times 37
    function automatic byte_t read_byte(input wb_addr_t addr, input byte_t key);
        wb_addr_t offset;
        if (addr >= VROM_BASE) begin
            offset = addr - VROM_BASE;
            return byte_t'(offset * 37);
        end
        offset = addr - VRAM_BASE;
        return byte_t'(offset) ^ key;
    endfunction

    assign wb_stall_o = (stall_q != 2'd0);
    assign wb_ack_o   = busy_q && (ack_q == 2'd0);
    assign wb_data_o  = wb_ack_o ? read_byte(addr_q, code_key_i) : '0;

    always_ff @(posedge wb_clock_i) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            stall_q <= 2'd0;
            ack_q   <= 2'd0;
        end else if (busy_q) begin
            if (ack_q == 2'd0) begin
                busy_q  <= 1'b0;                              // Ack taken this cycle
                stall_q <= 2'($urandom_range(stall_max_i, 0));
            end else begin
                ack_q <= ack_q - 1'b1;
            end
        end else if (wb_cyc_i && wb_stb_i) begin
            if (stall_q != 2'd0) begin
                stall_q <= stall_q - 1'b1;                    // Hold the master off
            end else begin
                busy_q <= 1'b1;                               // Request accepted
                addr_q <= wb_addr_i;
                ack_q  <= 2'($urandom_range(2, 0));           // Ack 1 to 3 clocks later
            end
        end
    end

endmodule

// ==== testbench/video_tb.sv ====
`timescale 1ns/100ps

module video_tb;
    import video_pkg::*;

    localparam int          CCLK         = PIXEL_DIV * CHAR_PIXELS;  // Clocks per character clock
    localparam int          FRAME        = H_TOTAL * RA_TOTAL * V_ROWS_TOTAL;  // Pairs per frame
    localparam int          RESET_CYCLES = 10;
    localparam int          TIMEOUT      = 4 * CCLK;   // Longest wait for the first request
    localparam int unsigned RNG_SEED     = 32'h3541_7e2e;
    localparam int          CHECK_BUS    = 1;  // Request count and addresses
    localparam int          CHECK_PIXELS = 2;  // Dots at the 33 + 2*bit points
    localparam int          CHECK_BLANK  = 4;  // Idle video outside the gate, every clock
    localparam int          CHECK_SYNC   = 8;  // Sync levels, every clock

    logic     wb_clock;
    logic     rst_n;
    logic     graphic_sel;
    logic     config_crt;
    int       stall_max;
    byte_t    code_key;
    wb_addr_t wb_addr;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    byte_t    wb_data;
    logic     wb_stall;
    logic     wb_ack;
    logic     h_sync;
    logic     v_sync;
    logic     video;

    video_top DUT (
        .wb_clock_i   (wb_clock),
        .rst_n_i      (rst_n),
        .graphic_i    (graphic_sel),
        .config_crt_i (config_crt),
        .wb_addr_o    (wb_addr),
        .wb_cyc_o     (wb_cyc),
        .wb_stb_o     (wb_stb),
        .wb_we_o      (wb_we),
        .wb_data_i    (wb_data),
        .wb_stall_i   (wb_stall),
        .wb_ack_i     (wb_ack),
        .h_sync_o     (h_sync),
        .v_sync_o     (v_sync),
        .video_o      (video)
    );

    tb_wb_memory u_memory (
        .wb_clock_i  (wb_clock),
        .rst_n_i     (rst_n),
        .wb_addr_i   (wb_addr),
        .wb_cyc_i    (wb_cyc),
        .wb_stb_i    (wb_stb),
        .stall_max_i (stall_max),
        .code_key_i  (code_key),
        .wb_data_o   (wb_data),
        .wb_stall_o  (wb_stall),
        .wb_ack_o    (wb_ack)
    );

    always #50 wb_clock = ~wb_clock;  // 100 ns period

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: %s expected %0h actual %0h", name, expected, actual);
            abort_run();
        end
    endtask

    // Raster position of character pair k, counted from the first pair after reset
    function automatic void pair_pos(input int k, output int h, output int ra, output int row);
        h   = k % H_TOTAL;
        ra  = (k / H_TOTAL) % RA_TOTAL;
        row = (k / (H_TOTAL * RA_TOTAL)) % V_ROWS_TOTAL;
    endfunction

    // Stages in bus order: even RAM, even ROM, odd RAM, odd ROM
    function automatic wb_addr_t expected_addr(input int ma, input int ra, input int stage,
                                               input logic graphic_bit, input byte_t key);
        byte_t code;
        code = byte_t'(2 * ma + stage / 2) ^ key;
        if (stage % 2 == 0) begin
            return VRAM_BASE + wb_addr_t'(2 * ma + stage / 2);
        end
        return VROM_BASE + wb_addr_t'({graphic_bit, code[6:0], 3'(ra)});
    endfunction

    // Dot b of a pair, MSB first, reverse applied, gate and polarity not
    function automatic logic glyph_dot(input int ma, input int ra, input int b,
                                       input logic graphic_bit, input byte_t key);
        byte_t       code;
        logic [10:0] index;
        byte_t       glyph;
        code  = byte_t'(2 * ma + b / 8) ^ key;  // Left half is the even code
        index = {graphic_bit, code[6:0], 3'(ra)};
        glyph = byte_t'(index * 37);
        return glyph[7 - b % 8] ^ code[7];
    endfunction

    // Applies the configuration and holds reset, last iteration samples the clock after release
    task automatic start_dut(input logic crt, input logic graphic_bit, input int stall_limit,
                             input byte_t key, input logic check_idle);
        int n;
        @(posedge wb_clock);
        #1;
        rst_n       = 1'b0;
        config_crt  = crt;
        graphic_sel = graphic_bit;
        stall_max   = stall_limit;
        code_key    = key;
        for (n = 0; n <= RESET_CYCLES; n++) begin
            @(posedge wb_clock);
            #1;
            rst_n = (n >= RESET_CYCLES - 1);
            @(negedge wb_clock);
            if (check_idle) begin
                check_equal("test_reset", 32'({3'b000, !crt, !crt, crt}),
                            32'({wb_cyc, wb_stb, wb_we, h_sync, v_sync, video}));
            end
        end
    endtask

    // First request marks the clock after the first cclk_en
    task automatic wait_first_request();
        int n;
        for (n = 0; n < TIMEOUT && !wb_stb; n++) begin
            @(negedge wb_clock);
        end
        if (!wb_stb) begin
            $display("timeout: no Wishbone request after reset");
            abort_run();
        end
    endtask

    // One frame from the sync point, pair j is on screen one character clock after its fetch
    task automatic scan_frame(input string name, input int checks);
        int   p;
        int   j;
        int   b;
        int   h;
        int   ra;
        int   row;
        int   req;
        logic gate;
        logic hs;
        logic vs;
        logic dot;
        req = 0;
        for (p = 0; p < (FRAME + 1) * CCLK; p++) begin
            if (p > 0) begin
                @(negedge wb_clock);
            end
            if ((checks & CHECK_BUS) != 0) begin
                if (p % CCLK == 0 && p > 0) begin
                    check_equal(name, 4, req);          // Four reads per pair
                end
                check_equal(name, 32'b10, 32'({wb_cyc, wb_we}));
            end
            if (p % CCLK == 0) begin
                req = 0;
            end
            if ((checks & CHECK_BUS) != 0 && wb_stb && !wb_stall) begin
                pair_pos(p / CCLK, h, ra, row);
                check_equal(name, 32'(expected_addr(row * H_DISPLAY + h, ra, req,
                                                    graphic_sel, code_key)), 32'(wb_addr));
                req++;
            end
            j    = p / CCLK - 1;
            b    = (p % CCLK) / PIXEL_DIV;
            gate = 1'b0;
            hs   = 1'b0;
            vs   = 1'b0;
            dot  = 1'b0;
            if (j >= 0) begin
                pair_pos(j, h, ra, row);
                gate = h < H_DISPLAY && row < V_ROWS_DISPLAY && ra < GLYPH_LINES;
                hs   = h >= H_SYNC_START && h < H_SYNC_START + H_SYNC_WIDTH;
                vs   = row == V_SYNC_ROW && ra < V_SYNC_LINES;
                dot  = gate && glyph_dot(row * H_DISPLAY + h, ra, b, graphic_sel, code_key);
            end
            if ((checks & CHECK_PIXELS) != 0 && p % PIXEL_DIV == 0) begin
                check_equal(name, 32'(dot ^ config_crt), 32'(video));
            end
            if ((checks & CHECK_BLANK) != 0 && !gate) begin
                check_equal(name, 32'(config_crt), 32'(video));
            end
            if ((checks & CHECK_SYNC) != 0) begin
                check_equal(name, 32'({hs ^ !config_crt, vs ^ !config_crt}),
                            32'({h_sync, v_sync}));
            end
        end
    endtask

    task automatic test_reset();
        start_dut(1'b0, 1'b0, 1, 8'h5A, 1'b1);
        start_dut(1'b1, 1'b0, 1, 8'h5A, 1'b1);
    endtask

    task automatic test_fetch_order();
        start_dut(1'b0, 1'b0, 1, 8'h5A, 1'b0);
        wait_first_request();
        scan_frame("test_fetch_order", CHECK_BUS);
    endtask

    task automatic test_pixels();
        start_dut(1'b0, 1'b0, 1, 8'h5A, 1'b0);
        wait_first_request();
        scan_frame("test_pixels", CHECK_PIXELS);
        start_dut(1'b0, 1'b0, 1, 8'hDA, 1'b0);  // Every screen code has bit 7 set
        wait_first_request();
        scan_frame("test_pixels", CHECK_PIXELS);
    endtask

    task automatic test_blank_rows();
        start_dut(1'b1, 1'b0, 1, 8'hDA, 1'b0);  // Reverse dots would show in blank lines
        wait_first_request();
        scan_frame("test_blank_rows", CHECK_BLANK);
    endtask

    task automatic test_sync_polarity();
        int crt;
        for (crt = 0; crt < 2; crt++) begin
            start_dut(crt[0], 1'b0, 1, 8'h5A, 1'b0);
            wait_first_request();
            scan_frame("test_sync_polarity", CHECK_SYNC | CHECK_PIXELS);
        end
    endtask

    task automatic test_graphic_stall();
        start_dut(1'b0, 1'b1, 2, 8'h5A, 1'b0);
        wait_first_request();
        scan_frame("test_graphic_stall", CHECK_BUS | CHECK_PIXELS);
    endtask

    initial begin
        wb_clock    = 1'b0;
        rst_n       = 1'b0;
        graphic_sel = 1'b0;
        config_crt  = 1'b0;
        stall_max   = 1;
        code_key    = 8'h5A;
        void'($urandom(RNG_SEED));
        test_reset();
        test_fetch_order();
        test_pixels();
        test_blank_rows();
        test_sync_polarity();
        test_graphic_stall();
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== build.f ====
hdl/video_pkg.sv
hdl/video_timing.sv
hdl/video_fetch_ctrl.sv
hdl/video_fetch_buf.sv
hdl/video_dotgen.sv
hdl/video_top.sv
testbench/tb_wb_memory.sv
testbench/video_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the video generator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module video_tb -f build.f -o video_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/video_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0
